//--- crtc_reg_pkg.sv
// ========================================
// CPU-visible register map of the CRTC
// Only R0-R7, R9, R12 and R13 have a timing meaning
// Defaults are the 8032 power-on values
// ========================================
`default_nettype none

package crtc_reg_pkg;

    localparam int REG_ADDR_W = 5;   // Address register width, selects one of 32 entries
    localparam int DATA_W     = 8;   // CPU data bus width
    localparam int MA_W       = 14;  // Refresh memory address width
    localparam int RA_W       = 5;   // Raster line address width
    localparam int ROW_W      = 7;   // Row counter and row fields

    // Register indices as the CPU writes them into the address register
    typedef enum logic [REG_ADDR_W-1:0] {
        reg_h_total       = 5'd0,   // Characters per line minus one
        reg_h_displayed   = 5'd1,   // Displayed characters per line
        reg_h_sync_pos    = 5'd2,   // Character position of horizontal sync
        reg_sync_width    = 5'd3,   // Low nibble is hsync, high nibble is vsync
        reg_v_total       = 5'd4,   // Rows per frame minus one
        reg_v_adjust      = 5'd5,   // Extra raster lines at frame end
        reg_v_displayed   = 5'd6,   // Displayed rows per frame
        reg_v_sync_pos    = 5'd7,   // Row where vertical sync starts
        reg_max_scan_line = 5'd9,   // Raster lines per row minus one
        reg_start_hi      = 5'd12,  // Start address bits 13:8
        reg_start_lo      = 5'd13   // Start address bits 7:0
    } crtc_reg_e;

    localparam logic [DATA_W-1:0] DEF_H_TOTAL       = 8'h31;
    localparam logic [DATA_W-1:0] DEF_H_DISPLAYED   = 8'h28;  // 40 columns
    localparam logic [DATA_W-1:0] DEF_H_SYNC_POS    = 8'h29;
    localparam logic [DATA_W-1:0] DEF_SYNC_WIDTH    = 8'h0f;  // Vsync nibble 0 gives 16 lines
    localparam logic [DATA_W-1:0] DEF_V_TOTAL       = 8'h20;
    localparam logic [DATA_W-1:0] DEF_V_ADJUST      = 8'h03;
    localparam logic [DATA_W-1:0] DEF_V_DISPLAYED   = 8'h19;  // 25 rows
    localparam logic [DATA_W-1:0] DEF_V_SYNC_POS    = 8'h1d;
    localparam logic [DATA_W-1:0] DEF_MAX_SCAN_LINE = 8'h09;
    localparam logic [DATA_W-1:0] DEF_START_HI      = 8'h10;  // Bit 12 set, video not inverted
    localparam logic [DATA_W-1:0] DEF_START_LO      = 8'h00;

    localparam int STATUS_VSYNC_BIT = 5;  // Status bit that shows vertical retrace

endpackage

`default_nettype wire

//--- crtc_timing_pkg.sv
// ========================================
// Types and widths shared by the timing blocks
// ========================================
`default_nettype none

package crtc_timing_pkg;

    // Frame end sequence, the adjust states are skipped when R5 is 0
    typedef enum logic [1:0] {
        st_normal,          // Rows of the frame are running
        st_frame_ending,    // Last raster line of the last row
        st_adjust_pending,  // Last line of the last row, adjust lines follow
        st_adjusting        // Vertical adjust lines
    } frame_state_e;

    localparam int VSYNC_W = 5;  // Holds 16 when the programmed width is 0
    localparam int HSYNC_W = 4;  // Sync width nibble of R3

endpackage

`default_nettype wire

//--- crtc_registers.sv
// ========================================
// CPU port of the CRTC, registers load 8032 values on reset
// Writes need clk_en_i, reads are combinational
// ========================================
`default_nettype none
`timescale 1ns/1ps

module crtc_registers (
    input  wire logic                              sys_clock_i,
    input  wire logic                              reset_i,
    input  wire logic                              clk_en_i,
    input  wire logic                              cs_i,    // Chip select
    input  wire logic                              rw_i,    // High reads, low writes
    input  wire logic                              rs_i,    // Low selects address/status
    input  wire logic [crtc_reg_pkg::DATA_W-1:0]   data_i,
    input  wire logic                              v_sync_i,
    output logic      [crtc_reg_pkg::DATA_W-1:0]   data_o,
    output logic                                   data_oe_o,
    output logic      [crtc_reg_pkg::DATA_W-1:0]   h_total_o,
    output logic      [crtc_reg_pkg::DATA_W-1:0]   h_displayed_o,
    output logic      [crtc_reg_pkg::DATA_W-1:0]   h_sync_pos_o,
    output logic      [crtc_timing_pkg::HSYNC_W-1:0] h_sync_width_o,
    output logic      [crtc_reg_pkg::DATA_W-crtc_timing_pkg::HSYNC_W-1:0] v_sync_width_o,
    output logic      [crtc_reg_pkg::ROW_W-1:0]    v_total_o,
    output logic      [crtc_reg_pkg::ROW_W-1:0]    v_displayed_o,
    output logic      [crtc_reg_pkg::ROW_W-1:0]    v_sync_pos_o,
    output logic      [crtc_reg_pkg::RA_W-1:0]     v_adjust_o,
    output logic      [crtc_reg_pkg::RA_W-1:0]     max_scan_line_o,
    output logic      [crtc_reg_pkg::MA_W-1:0]     start_addr_o
);

    logic [crtc_reg_pkg::REG_ADDR_W-1:0] addr_q;  // Address register
    logic [crtc_reg_pkg::DATA_W-1:0]     regs [2**crtc_reg_pkg::REG_ADDR_W];
    logic [crtc_reg_pkg::DATA_W-1:0]     status;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            addr_q <= '0;
            for (int i = 0; i < 2**crtc_reg_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;  // Unused entries read back as 0
            end
            regs[crtc_reg_pkg::reg_h_total]       <= crtc_reg_pkg::DEF_H_TOTAL;
            regs[crtc_reg_pkg::reg_h_displayed]   <= crtc_reg_pkg::DEF_H_DISPLAYED;
            regs[crtc_reg_pkg::reg_h_sync_pos]    <= crtc_reg_pkg::DEF_H_SYNC_POS;
            regs[crtc_reg_pkg::reg_sync_width]    <= crtc_reg_pkg::DEF_SYNC_WIDTH;
            regs[crtc_reg_pkg::reg_v_total]       <= crtc_reg_pkg::DEF_V_TOTAL;
            regs[crtc_reg_pkg::reg_v_adjust]      <= crtc_reg_pkg::DEF_V_ADJUST;
            regs[crtc_reg_pkg::reg_v_displayed]   <= crtc_reg_pkg::DEF_V_DISPLAYED;
            regs[crtc_reg_pkg::reg_v_sync_pos]    <= crtc_reg_pkg::DEF_V_SYNC_POS;
            regs[crtc_reg_pkg::reg_max_scan_line] <= crtc_reg_pkg::DEF_MAX_SCAN_LINE;
            regs[crtc_reg_pkg::reg_start_hi]      <= crtc_reg_pkg::DEF_START_HI;
            regs[crtc_reg_pkg::reg_start_lo]      <= crtc_reg_pkg::DEF_START_LO;
        end else if (clk_en_i && cs_i && !rw_i) begin
            if (!rs_i) begin
                addr_q <= data_i[crtc_reg_pkg::REG_ADDR_W-1:0];  // Select a register
            end else begin
                regs[addr_q] <= data_i;  // Write the selected register
            end
        end
    end

    // Status byte carries only the vertical retrace flag
    always_comb begin
        status = '0;
        status[crtc_reg_pkg::STATUS_VSYNC_BIT] = v_sync_i;
    end

    assign data_oe_o = cs_i && rw_i;
    assign data_o    = rs_i ? regs[addr_q] : status;

    // Fields as the timing blocks see them, upper bits of short registers are ignored
    assign h_total_o       = regs[crtc_reg_pkg::reg_h_total];
    assign h_displayed_o   = regs[crtc_reg_pkg::reg_h_displayed];
    assign h_sync_pos_o    = regs[crtc_reg_pkg::reg_h_sync_pos];
    assign h_sync_width_o  = regs[crtc_reg_pkg::reg_sync_width][crtc_timing_pkg::HSYNC_W-1:0];
    assign v_sync_width_o  = regs[crtc_reg_pkg::reg_sync_width]
                                 [crtc_reg_pkg::DATA_W-1:crtc_timing_pkg::HSYNC_W];
    assign v_total_o       = regs[crtc_reg_pkg::reg_v_total][crtc_reg_pkg::ROW_W-1:0];
    assign v_displayed_o   = regs[crtc_reg_pkg::reg_v_displayed][crtc_reg_pkg::ROW_W-1:0];
    assign v_sync_pos_o    = regs[crtc_reg_pkg::reg_v_sync_pos][crtc_reg_pkg::ROW_W-1:0];
    assign v_adjust_o      = regs[crtc_reg_pkg::reg_v_adjust][crtc_reg_pkg::RA_W-1:0];
    assign max_scan_line_o = regs[crtc_reg_pkg::reg_max_scan_line][crtc_reg_pkg::RA_W-1:0];
    assign start_addr_o    = {regs[crtc_reg_pkg::reg_start_hi]
                                  [crtc_reg_pkg::MA_W-crtc_reg_pkg::DATA_W-1:0],
                              regs[crtc_reg_pkg::reg_start_lo]};

endmodule

`default_nettype wire

//--- crtc_horizontal.sv
// ========================================
// Character counter and horizontal timing
// Sync width 0 disables the pulse
// ========================================
`default_nettype none
`timescale 1ns/1ps

module crtc_horizontal (
    input  wire logic                                sys_clock_i,
    input  wire logic                                reset_i,
    input  wire logic                                clk_en_i,
    input  wire logic [crtc_reg_pkg::DATA_W-1:0]     h_total_i,
    input  wire logic [crtc_reg_pkg::DATA_W-1:0]     h_displayed_i,
    input  wire logic [crtc_reg_pkg::DATA_W-1:0]     h_sync_pos_i,
    input  wire logic [crtc_timing_pkg::HSYNC_W-1:0] h_sync_width_i,
    output logic                                     line_end_o,
    output logic                                     last_col_o,
    output logic                                     h_sync_o,
    output logic                                     h_display_o
);

    logic [crtc_reg_pkg::DATA_W-1:0]     char_cnt;
    logic [crtc_timing_pkg::HSYNC_W-1:0] sync_cnt;  // Ticks of sync already output

    assign line_end_o = char_cnt == h_total_i;
    assign last_col_o = char_cnt == h_displayed_i;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            char_cnt <= '0;
        end else if (clk_en_i) begin
            char_cnt <= line_end_o ? '0 : char_cnt + 1'b1;  // Period is h_total + 1 ticks
        end
    end

    // Display window covers counts 1 to h_displayed
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            h_display_o <= 1'b1;
        end else if (clk_en_i) begin
            if (last_col_o) begin
                h_display_o <= 1'b0;
            end else if (char_cnt == '0) begin
                h_display_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            h_sync_o <= 1'b0;
            sync_cnt <= '0;
        end else if (clk_en_i) begin
            if (h_sync_o) begin
                if (sync_cnt + 1'b1 == h_sync_width_i) begin
                    h_sync_o <= 1'b0;  // Width reached
                    sync_cnt <= '0;
                end else begin
                    sync_cnt <= sync_cnt + 1'b1;
                end
            end else if (char_cnt == h_sync_pos_i && h_sync_width_i != '0) begin
                h_sync_o <= 1'b1;
                sync_cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- crtc_vertical.sv
// ========================================
// Raster, row and frame timing, one update per line end
// Vsync width field 0 means 16 lines
// Frame is (R4+1)*(R9+1)+R5 raster lines
// ========================================
`default_nettype none
`timescale 1ns/1ps

module crtc_vertical (
    input  wire logic                              sys_clock_i,
    input  wire logic                              reset_i,
    input  wire logic                              clk_en_i,
    input  wire logic                              line_end_i,
    input  wire logic [crtc_reg_pkg::ROW_W-1:0]    v_total_i,
    input  wire logic [crtc_reg_pkg::ROW_W-1:0]    v_displayed_i,
    input  wire logic [crtc_reg_pkg::ROW_W-1:0]    v_sync_pos_i,
    input  wire logic [crtc_reg_pkg::DATA_W-crtc_timing_pkg::HSYNC_W-1:0] v_sync_width_i,
    input  wire logic [crtc_reg_pkg::RA_W-1:0]     v_adjust_i,
    input  wire logic [crtc_reg_pkg::RA_W-1:0]     max_scan_line_i,
    output logic                                   frame_start_o,
    output logic                                   last_line_o,
    output logic      [crtc_reg_pkg::RA_W-1:0]     ra_o,
    output logic                                   v_sync_o,
    output logic                                   v_display_o
);

    crtc_timing_pkg::frame_state_e    state_q, state_d;
    logic [crtc_reg_pkg::ROW_W-1:0]   row_cnt;
    logic [crtc_reg_pkg::RA_W-1:0]    adjust_cnt;  // Adjust lines already output
    logic [crtc_timing_pkg::VSYNC_W-1:0] vs_cnt;
    logic [crtc_timing_pkg::VSYNC_W-1:0] vs_width;
    logic                             vs_done;     // Sync already given in this frame
    logic                             last_row;
    logic                             in_last_line;  // Either state of the frame's last line

    assign last_line_o  = ra_o == max_scan_line_i;
    assign last_row     = row_cnt == v_total_i;
    assign in_last_line = state_q == crtc_timing_pkg::st_frame_ending ||
                          state_q == crtc_timing_pkg::st_adjust_pending;
    assign vs_width     = v_sync_width_i == '0 ? 5'd16 : {1'b0, v_sync_width_i};

    // Frame ends at the last line end, or after v_adjust extra lines
    assign frame_start_o = line_end_i &&
        ((in_last_line && v_adjust_i == '0) ||
         (state_q == crtc_timing_pkg::st_adjusting && adjust_cnt + 1'b1 == v_adjust_i));

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            crtc_timing_pkg::st_normal: begin
                if (last_row && last_line_o) state_d = crtc_timing_pkg::st_frame_ending;
            end
            crtc_timing_pkg::st_frame_ending: begin
                if (frame_start_o) state_d = crtc_timing_pkg::st_normal;
                else if (line_end_i) state_d = crtc_timing_pkg::st_adjusting;
                else if (v_adjust_i != '0) state_d = crtc_timing_pkg::st_adjust_pending;
            end
            crtc_timing_pkg::st_adjust_pending: begin
                if (frame_start_o) state_d = crtc_timing_pkg::st_normal;
                else if (line_end_i) state_d = crtc_timing_pkg::st_adjusting;
            end
            crtc_timing_pkg::st_adjusting: begin
                if (frame_start_o) state_d = crtc_timing_pkg::st_normal;
            end
            default: state_d = crtc_timing_pkg::st_normal;
        endcase
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            state_q    <= crtc_timing_pkg::st_normal;
            ra_o       <= '0;
            row_cnt    <= '0;
            adjust_cnt <= '0;
        end else if (clk_en_i) begin
            state_q <= state_d;
            if (frame_start_o) begin
                ra_o       <= '0;
                row_cnt    <= '0;
                adjust_cnt <= '0;
            end else if (line_end_i) begin
                // Raster keeps counting through the adjust lines
                ra_o <= last_line_o ? '0 : ra_o + 1'b1;
                if (last_line_o) row_cnt <= row_cnt + 1'b1;
                if (state_q == crtc_timing_pkg::st_adjusting) adjust_cnt <= adjust_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            v_display_o <= 1'b1;
        end else if (clk_en_i) begin
            if (frame_start_o) v_display_o <= 1'b1;
            else if (row_cnt == v_displayed_i) v_display_o <= 1'b0;  // Rows past R6 stay blank
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            v_sync_o <= 1'b0;
            vs_cnt   <= '0;
            vs_done  <= 1'b0;
        end else if (clk_en_i) begin
            if (frame_start_o) vs_done <= 1'b0;
            if (v_sync_o) begin
                if (line_end_i) begin
                    vs_cnt <= vs_cnt + 1'b1;
                    if (vs_cnt + 1'b1 == vs_width) v_sync_o <= 1'b0;  // Counted in lines
                end
            end else if (row_cnt == v_sync_pos_i && !vs_done) begin
                v_sync_o <= 1'b1;
                vs_cnt   <= '0;
                vs_done  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- crtc_address.sv
// ========================================
// Refresh address generator
// Each raster line of a row repeats the same addresses
// ========================================
`default_nettype none
`timescale 1ns/1ps

module crtc_address (
    input  wire logic                           sys_clock_i,
    input  wire logic                           reset_i,
    input  wire logic                           clk_en_i,
    input  wire logic                           frame_start_i,
    input  wire logic                           line_end_i,
    input  wire logic                           last_col_i,
    input  wire logic                           last_line_i,
    input  wire logic [crtc_reg_pkg::MA_W-1:0]  start_addr_i,
    output logic      [crtc_reg_pkg::MA_W-1:0]  ma_o
);

    logic [crtc_reg_pkg::MA_W-1:0] row_start;  // Address of the current row's first character
    logic [crtc_reg_pkg::MA_W-1:0] row_next;

    // On the last raster line the next row begins where display ended
    assign row_next = (last_line_i && last_col_i) ? ma_o : row_start;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            row_start <= '0;
            ma_o      <= '0;
        end else if (clk_en_i) begin
            if (frame_start_i) begin
                row_start <= start_addr_i;
                ma_o      <= start_addr_i;
            end else begin
                row_start <= row_next;
                ma_o      <= line_end_i ? row_next : ma_o + 1'b1;  // Reload at line end
            end
        end
    end

endmodule

`default_nettype wire

//--- crtc_top.sv
// ========================================
// 6545-style CRTC, no cursor, light pen or interlace
// All timing advances on clk_en_i ticks
// ========================================
`default_nettype none
`timescale 1ns/1ps

module crtc_top (
    input  wire logic                             sys_clock_i,
    input  wire logic                             reset_i,
    input  wire logic                             clk_en_i,  // Character clock enable
    input  wire logic                             cs_i,
    input  wire logic                             rw_i,
    input  wire logic                             rs_i,
    input  wire logic [crtc_reg_pkg::DATA_W-1:0]  data_i,
    output logic      [crtc_reg_pkg::DATA_W-1:0]  data_o,
    output logic                                  data_oe_o,
    output logic                                  h_sync_o,
    output logic                                  v_sync_o,
    output logic                                  de_o,
    output logic      [crtc_reg_pkg::MA_W-1:0]    ma_o,
    output logic      [crtc_reg_pkg::RA_W-1:0]    ra_o
);

    logic [crtc_reg_pkg::DATA_W-1:0]     h_total, h_displayed, h_sync_pos;
    logic [crtc_timing_pkg::HSYNC_W-1:0] h_sync_width;
    logic [crtc_reg_pkg::DATA_W-crtc_timing_pkg::HSYNC_W-1:0] v_sync_width_raw;
    logic [crtc_reg_pkg::ROW_W-1:0]      v_total, v_displayed, v_sync_pos;
    logic [crtc_reg_pkg::RA_W-1:0]       v_adjust, max_scan_line;
    logic [crtc_reg_pkg::MA_W-1:0]       start_addr;
    logic line_end, last_col, h_display;
    logic frame_start, last_line, v_display;

    crtc_registers u_registers (
        .sys_clock_i, .reset_i, .clk_en_i, .cs_i, .rw_i, .rs_i, .data_i,
        .v_sync_i        (v_sync_o),  // Status byte shows vertical retrace
        .data_o, .data_oe_o,
        .h_total_o       (h_total),
        .h_displayed_o   (h_displayed),
        .h_sync_pos_o    (h_sync_pos),
        .h_sync_width_o  (h_sync_width),
        .v_sync_width_o  (v_sync_width_raw),
        .v_total_o       (v_total),
        .v_displayed_o   (v_displayed),
        .v_sync_pos_o    (v_sync_pos),
        .v_adjust_o      (v_adjust),
        .max_scan_line_o (max_scan_line),
        .start_addr_o    (start_addr)
    );

    crtc_horizontal u_horizontal (
        .sys_clock_i, .reset_i, .clk_en_i,
        .h_total_i      (h_total),
        .h_displayed_i  (h_displayed),
        .h_sync_pos_i   (h_sync_pos),
        .h_sync_width_i (h_sync_width),
        .line_end_o     (line_end),
        .last_col_o     (last_col),
        .h_sync_o,
        .h_display_o    (h_display)
    );

    crtc_vertical u_vertical (
        .sys_clock_i, .reset_i, .clk_en_i,
        .line_end_i      (line_end),
        .v_total_i       (v_total),
        .v_displayed_i   (v_displayed),
        .v_sync_pos_i    (v_sync_pos),
        .v_sync_width_i  (v_sync_width_raw),
        .v_adjust_i      (v_adjust),
        .max_scan_line_i (max_scan_line),
        .frame_start_o   (frame_start),
        .last_line_o     (last_line),
        .ra_o, .v_sync_o,
        .v_display_o     (v_display)
    );

    crtc_address u_address (
        .sys_clock_i, .reset_i, .clk_en_i,
        .frame_start_i (frame_start),
        .line_end_i    (line_end),
        .last_col_i    (last_col),
        .last_line_i   (last_line),
        .start_addr_i  (start_addr),
        .ma_o
    );

    assign de_o = h_display && v_display;  // Inside both display windows

endmodule

`default_nettype wire

//--- tb_crtc.sv
// ========================================
// Self-checking testbench for crtc_top
// Table entries need h_displayed <= h_sync_pos < h_total
// and vsync inside the blank rows of the frame
// ========================================
`default_nettype none
`timescale 1ns/1ps

module tb_crtc;

    localparam int CLK_PERIOD = 100;
    localparam int N_CFG      = 3;
    localparam int MARGIN     = 4096;  // Cycles per entry for reset, bus traffic and the first frame

    typedef struct packed {
        logic [7:0] r0, r1, r2, r3, r4, r5, r6, r7, r9, r12, r13;
    } crtc_cfg_t;

    // Columns are R0 R1 R2 R3 R4 R5 R6 R7 R9 R12 R13, the last entry runs with random clk_en_i
    crtc_cfg_t cfg_table [N_CFG] = '{
        '{8'h1f, 8'h14, 8'h16, 8'h34, 8'h07, 8'h02, 8'h05, 8'h06, 8'h03, 8'h00, 8'h10},
        '{8'h17, 8'h10, 8'h12, 8'h02, 8'h09, 8'h00, 8'h04, 8'h04, 8'h02, 8'h3f, 8'hf8},
        '{8'h13, 8'h0c, 8'h0e, 8'h53, 8'h05, 8'h05, 8'h03, 8'h04, 8'h01, 8'h12, 8'h34}
    };

    logic        sys_clock_i, reset_i, clk_en_i, cs_i, rw_i, rs_i;
    logic [7:0]  data_i, data_o;
    logic        data_oe_o, h_sync_o, v_sync_o, de_o;
    logic [13:0] ma_o;
    logic [4:0]  ra_o;
    integer      seed = 32'h69ab_a198;
    int          errors = 0;
    int          checks = 0;

    crtc_top DUT (
        .sys_clock_i, .reset_i, .clk_en_i, .cs_i, .rw_i, .rs_i, .data_i,
        .data_o, .data_oe_o, .h_sync_o, .v_sync_o, .de_o, .ma_o, .ra_o
    );

    initial begin
        sys_clock_i = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clock_i = ~sys_clock_i;
    end

    // Frame is (R4+1) rows of (R9+1) lines plus R5 adjust lines
    function automatic int frame_lines(input crtc_cfg_t c);
        return (int'(c.r4[6:0]) + 1) * (int'(c.r9[4:0]) + 1) + int'(c.r5[4:0]);
    endfunction

    function automatic int vsync_lines(input crtc_cfg_t c);
        return (c.r3[7:4] == 4'h0) ? 16 : int'(c.r3[7:4]);  // Field 0 stands for 16
    endfunction

    task automatic compare(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge sys_clock_i);
        reset_i  <= 1'b1;
        clk_en_i <= 1'b1;
        repeat (4) @(posedge sys_clock_i);
        reset_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic sel, input logic [7:0] value);
        @(posedge sys_clock_i);
        cs_i   <= 1'b1;
        rw_i   <= 1'b0;
        rs_i   <= sel;
        data_i <= value;
        @(negedge sys_clock_i);
        compare("data_oe_o", data_oe_o, 0);  // A write cycle leaves the bus undriven
        @(posedge sys_clock_i);  // The DUT takes the write on this tick
        cs_i   <= 1'b0;
        rw_i   <= 1'b1;
    endtask

    // Register read must echo the write, status holds only the vsync bit
    task automatic write_and_read_back(input logic [4:0] index, input logic [7:0] value);
        bus_write(1'b0, {3'b000, index});
        bus_write(1'b1, value);
        @(posedge sys_clock_i);
        cs_i <= 1'b1;
        rs_i <= 1'b1;
        @(negedge sys_clock_i);
        compare("data_o", data_o, value);
        compare("data_oe_o", data_oe_o, 1);
        @(posedge sys_clock_i);
        rs_i <= 1'b0;
        @(negedge sys_clock_i);
        compare("data_o status", data_o, {2'b00, v_sync_o, 5'b00000});
        @(posedge sys_clock_i);
        cs_i <= 1'b0;
        @(negedge sys_clock_i);
        compare("data_oe_o", data_oe_o, 0);  // Deselected bus must not drive
    endtask

    task automatic program_config(input crtc_cfg_t c);
        write_and_read_back(crtc_reg_pkg::reg_max_scan_line, c.r9);  // First, so ra stays in range
        write_and_read_back(crtc_reg_pkg::reg_h_total, c.r0);
        write_and_read_back(crtc_reg_pkg::reg_h_displayed, c.r1);
        write_and_read_back(crtc_reg_pkg::reg_h_sync_pos, c.r2);
        write_and_read_back(crtc_reg_pkg::reg_sync_width, c.r3);
        write_and_read_back(crtc_reg_pkg::reg_v_total, c.r4);
        write_and_read_back(crtc_reg_pkg::reg_v_adjust, c.r5);
        write_and_read_back(crtc_reg_pkg::reg_v_displayed, c.r6);
        write_and_read_back(crtc_reg_pkg::reg_v_sync_pos, c.r7);
        write_and_read_back(crtc_reg_pkg::reg_start_hi, c.r12);
        write_and_read_back(crtc_reg_pkg::reg_start_lo, c.r13);
    endtask

    // One sample per tick at the falling edge, checks start after the first vsync rise
    task automatic measure_frames(input crtc_cfg_t c, input logic random_enable);
        int          line_ticks = 0;
        int          hs_high = 0;
        int          de_ticks = 0;
        int          lines = 0;
        int          disp_lines = 0;
        int          vs_lines = 0;
        int          vs_rises = 0;
        int          d_line = 0;  // Displayed line index within the frame
        int          rows_lines = int'(c.r9[4:0]) + 1;
        logic        hs_prev = 1'b0;
        logic        vs_prev = 1'b0;
        logic        de_prev = 1'b0;
        logic [4:0]  ra_prev = '0;
        logic [13:0] ma_prev = '0;
        logic [13:0] start = {c.r12[5:0], c.r13};
        logic [31:0] rnd;
        while (vs_rises < 3) begin
            @(posedge sys_clock_i);
            rnd = $random(seed);
            clk_en_i <= random_enable ? rnd[0] : 1'b1;
            cs_i     <= 1'b1;  // Status register stays selected for reading
            @(negedge sys_clock_i);
            if (clk_en_i) begin
                if (!h_sync_o && hs_prev && vs_rises > 0) begin
                    compare("h_sync_o width", hs_high, c.r3[3:0]);
                end
                if (h_sync_o && !hs_prev) begin
                    if (vs_rises > 0) begin
                        compare("h_sync_o period", line_ticks, c.r0 + 1);
                        if (de_ticks != 0) compare("de_o ticks", de_ticks, c.r1);
                        if (ra_o != 0 || ra_prev == c.r9[4:0]) begin
                            compare("ra_o", ra_o, (ra_prev == c.r9[4:0]) ? 0 : ra_prev + 1);
                        end
                    end
                    if (de_ticks == 0) d_line = 0;  // A blank line precedes the next frame
                    else disp_lines++;
                    if (v_sync_o) vs_lines++;
                    lines++;
                    ra_prev = ra_o;
                    line_ticks = 0;
                    hs_high = 0;
                    de_ticks = 0;
                end
                if (v_sync_o && !vs_prev) begin
                    compare("data_o status", data_o, 8'h20);  // Retrace shows in bit 5
                    if (vs_rises > 0) begin
                        compare("frame lines", lines, frame_lines(c));
                        compare("de_o lines", disp_lines, int'(c.r6[6:0]) * rows_lines);
                    end
                    vs_rises++;
                    lines = 0;
                    disp_lines = 0;
                    vs_lines = 0;
                end
                if (!v_sync_o && vs_prev && vs_rises > 0) begin
                    compare("v_sync_o lines", vs_lines, vsync_lines(c));
                end
                // Address one tick before display enable is the row's first character
                if (de_o && !de_prev) begin
                    if (vs_rises > 0) begin
                        compare("ma_o", ma_prev,
                                (start + (d_line / rows_lines) * c.r1) % 16384);
                    end
                    d_line++;
                end
                if (h_sync_o) hs_high++;
                if (de_o) de_ticks++;
                line_ticks++;
                hs_prev = h_sync_o;
                vs_prev = v_sync_o;
                de_prev = de_o;
                ma_prev = ma_o;
            end
        end
    endtask

    initial begin : watchdog
        int limit;
        int cycles;
        limit = 0;
        cycles = 0;
        for (int e = 0; e < N_CFG; e++) begin
            limit += 3 * frame_lines(cfg_table[e]) * (int'(cfg_table[e].r0) + 1) * 4 + MARGIN;
        end
        forever begin
            @(posedge sys_clock_i);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles, vsync stopped arriving", cycles);
                $display("Regression failed");
                $finish;
            end
        end
    end

    initial begin
        reset_i  <= 1'b0;
        clk_en_i <= 1'b1;
        cs_i     <= 1'b0;
        rw_i     <= 1'b1;
        rs_i     <= 1'b0;
        data_i   <= '0;
        for (int e = 0; e < N_CFG; e++) begin
            apply_reset();
            program_config(cfg_table[e]);
            measure_frames(cfg_table[e], e == N_CFG - 1);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
crtc_reg_pkg.sv
crtc_timing_pkg.sv
crtc_registers.sv
crtc_horizontal.sv
crtc_vertical.sv
crtc_address.sv
crtc_top.sv
tb_crtc.sv

//--- Bender.yml
package:
  name: crtc

sources:
  - crtc_reg_pkg.sv
  - crtc_timing_pkg.sv
  - crtc_registers.sv
  - crtc_horizontal.sv
  - crtc_vertical.sv
  - crtc_address.sv
  - crtc_top.sv
  - target: simulation
    files:
      - tb_crtc.sv
